// ==== hw/dev_table.sv ====
// device table slave
// words 0 to 2 describe the memory, the table itself and the invalid device
// the command word turns a write into rst0/rst1 pulses for the sequencer

`timescale 1ns/1ps
`default_nettype none

`include "pi1_sys_defines.svh"

module dev_table (
	input  logic                   clk120mhz,
	input  logic                   sys_rst_i,
	input  pi1_sys_pkg::pi1_req_t  req_i,
	output logic [`PI1_DATA_W-1:0] data_o,
	output logic                   rst0_o,
	output logic                   rst1_o
);

	import pi1_sys_pkg::*;

	localparam int IDX_W = $clog2(`DEVTBL_MAPSZ);

	localparam logic [IDX_W-1:0] IDX_RAM     = IDX_W'(0);
	localparam logic [IDX_W-1:0] IDX_DEVTBL  = IDX_W'(1);
	localparam logic [IDX_W-1:0] IDX_INVALID = IDX_W'(2);
	localparam logic [IDX_W-1:0] IDX_CMD     = IDX_W'(`DEVTBL_CMD_IDX);

	logic [IDX_W-1:0]       idx;
	dev_entry_t             entry;
	logic [`PI1_DATA_W-1:0] data_q;
	logic                   rd_en;
	logic                   cmd_wr;
	logic                   rst0_q;
	logic                   rst1_q;

	// table is aligned, the low address bits pick the word
	assign idx   = req_i.addr[IDX_W-1:0];
	assign rd_en = (req_i.op == op_read) || (req_i.op == op_swap);

	assign cmd_wr = ((req_i.op == op_write) || (req_i.op == op_swap)) &&
		(idx == IDX_CMD) && req_i.sel[0];

	// nothing here raises interrupts
	always_comb begin
		entry = '0;
		case (idx)
			IDX_RAM: begin
				entry.id    = 7'(`ID_RAM);
				entry.mapsz = 24'(`RAM_MAPSZ);
			end
			IDX_DEVTBL: begin
				entry.id    = 7'(`ID_DEVTBL);
				entry.mapsz = 24'(`DEVTBL_MAPSZ);
			end
			// invalid device covers whatever is left, no fixed size
			IDX_INVALID: begin
				entry.id    = 7'(`ID_INVALID);
				entry.mapsz = '0;
			end
			default: entry = '0;
		endcase
	end

	always_ff @(posedge clk120mhz) begin
		if (rd_en)
			data_q <= entry;
	end

	// one-cycle command pulses
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else begin
			rst0_q <= cmd_wr && req_i.data[`RST_CMD_RST0_BIT];
			rst1_q <= cmd_wr && req_i.data[`RST_CMD_RST1_BIT];
		end
	end

	assign data_o = data_q;
	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

`default_nettype wire

// ==== hw/pi1_router.sv ====
// PI1 router for a single master
// decodes the word address against the memory and device table windows
// steers the request, returns the data of the slave that took the access
// answers unmapped addresses itself with zero data

`timescale 1ns/1ps
`default_nettype none

`include "pi1_sys_defines.svh"

module pi1_router (
	input  logic                   clk120mhz,
	input  logic                   sys_rst_i,
	input  pi1_sys_pkg::pi1_req_t  m_req_i,
	output pi1_sys_pkg::pi1_rsp_t  m_rsp_o,
	output pi1_sys_pkg::pi1_req_t  ram_req_o,
	input  logic [`PI1_DATA_W-1:0] ram_data_i,
	output pi1_sys_pkg::pi1_req_t  tbl_req_o,
	input  logic [`PI1_DATA_W-1:0] tbl_data_i
);

	import pi1_sys_pkg::*;

	// device table sits right above the memory
	localparam logic [`PI1_ADDR_W-1:0] TBL_BASE = `PI1_ADDR_W'(`RAM_MAPSZ);
	localparam logic [`PI1_ADDR_W-1:0] TBL_END  = `PI1_ADDR_W'(`RAM_MAPSZ + `DEVTBL_MAPSZ);

	slave_sel_e sel_now;
	slave_sel_e sel_q;
	logic       accept;

	always_comb begin
		if (m_req_i.addr < TBL_BASE)
			sel_now = sel_ram;
		else if (m_req_i.addr < TBL_END)
			sel_now = sel_devtbl;
		else
			sel_now = sel_invalid;
	end

	// slaves never stall, so the only hold-off is the system reset
	assign accept = (m_req_i.op != op_none) && !sys_rst_i;

	always_comb begin
		ram_req_o = m_req_i;
		if (!(accept && (sel_now == sel_ram)))
			ram_req_o.op = op_none;
	end

	always_comb begin
		tbl_req_o = m_req_i;
		if (!(accept && (sel_now == sel_devtbl)))
			tbl_req_o.op = op_none;
	end

	// remembers who owns the data coming back next cycle
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i)
			sel_q <= sel_invalid;
		else if (accept)
			sel_q <= sel_now;
	end

	always_comb begin
		case (sel_q)
			sel_ram:    m_rsp_o.data = ram_data_i;
			sel_devtbl: m_rsp_o.data = tbl_data_i;
			default:    m_rsp_o.data = '0;
		endcase
		m_rsp_o.rdy = !sys_rst_i;
	end

	a_one_slave: assert property (@(posedge clk120mhz)
		!((ram_req_o.op != op_none) && (tbl_req_o.op != op_none)));

endmodule

`default_nettype wire

// ==== hw/pi1_sys_defines.svh ====
// bus widths for the PI1 peripheral bus
// slave map sizes and slave ids
// reset countdown width and software reset command bits

`ifndef PI1_SYS_DEFINES_SVH
`define PI1_SYS_DEFINES_SVH

// bus word, byte select and word address widths
`define PI1_DATA_W 32
`define PI1_SEL_W 4
`define PI1_ADDR_W 30

// memory at word 0, device table right after it
`define RAM_MAPSZ 256
`define DEVTBL_MAPSZ 16
`define DEVTBL_CMD_IDX 15

// slave ids as reported by the device table
`define ID_RAM 1
`define ID_DEVTBL 7
`define ID_INVALID 0

// reset countdown
`define RST_CNTR_W 4

// software reset command word
`define RST_CMD_RST0_BIT 0
`define RST_CMD_RST1_BIT 1

`endif

// ==== hw/pi1_sys_pkg.sv ====
// PI1 bus operation encoding
// master request and slave response structs
// device table entry layout
// slave select used by the router

`default_nettype none

`include "pi1_sys_defines.svh"

package pi1_sys_pkg;

	// same encoding as the PI1 op lines
	typedef enum logic [1:0] {
		op_none  = 2'd0,
		op_write = 2'd1,
		op_read  = 2'd2,
		op_swap  = 2'd3
	} pi1_op_e;

	typedef struct packed {
		pi1_op_e                  op;
		logic [`PI1_ADDR_W-1:0]   addr;
		logic [`PI1_DATA_W-1:0]   data;
		logic [`PI1_SEL_W-1:0]    sel;
	} pi1_req_t;

	typedef struct packed {
		logic [`PI1_DATA_W-1:0]   data;
		logic                     rdy;
	} pi1_rsp_t;

	// one device table word, map size counted in words
	typedef struct packed {
		logic        useintr;
		logic [6:0]  id;
		logic [23:0] mapsz;
	} dev_entry_t;

	typedef enum logic [1:0] {
		sel_ram     = 2'd0,
		sel_devtbl  = 2'd1,
		sel_invalid = 2'd2
	} slave_sel_e;

endpackage

`default_nettype wire

// ==== hw/pi1_sys_top.sv ====
// system-control fabric top level
// reset sequencer, PI1 router, word memory and device table
// one external master port, everything on clk120mhz

`timescale 1ns/1ps
`default_nettype none

`include "pi1_sys_defines.svh"

module pi1_sys_top (
	input  logic                  clk120mhz,
	input  logic                  rst_p,
	input  pi1_sys_pkg::pi1_req_t m_req_i,
	output pi1_sys_pkg::pi1_rsp_t m_rsp_o,
	output logic                  sys_rst_o,
	output logic                  pwroff_o
);

	import pi1_sys_pkg::*;

	logic                   sys_rst;
	logic                   ram_clear;
	logic                   tbl_rst0;
	logic                   tbl_rst1;
	pi1_req_t               ram_req;
	pi1_req_t               tbl_req;
	logic [`PI1_DATA_W-1:0] ram_data;
	logic [`PI1_DATA_W-1:0] tbl_data;

	reset_seq u_reset_seq (
		.clk120mhz   (clk120mhz),
		.rst_p       (rst_p),
		.rst0_i      (tbl_rst0),
		.rst1_i      (tbl_rst1),
		.sys_rst_o   (sys_rst),
		.ram_clear_o (ram_clear),
		.pwroff_o    (pwroff_o)
	);

	pi1_router u_pi1_router (
		.clk120mhz  (clk120mhz),
		.sys_rst_i  (sys_rst),
		.m_req_i    (m_req_i),
		.m_rsp_o    (m_rsp_o),
		.ram_req_o  (ram_req),
		.ram_data_i (ram_data),
		.tbl_req_o  (tbl_req),
		.tbl_data_i (tbl_data)
	);

	word_ram u_word_ram (
		.clk120mhz   (clk120mhz),
		.sys_rst_i   (sys_rst),
		.ram_clear_i (ram_clear),
		.req_i       (ram_req),
		.data_o      (ram_data)
	);

	dev_table u_dev_table (
		.clk120mhz (clk120mhz),
		.sys_rst_i (sys_rst),
		.req_i     (tbl_req),
		.data_o    (tbl_data),
		.rst0_o    (tbl_rst0),
		.rst1_o    (tbl_rst1)
	);

	assign sys_rst_o = sys_rst;

endmodule

`default_nettype wire

// ==== hw/reset_seq.sv ====
// reset sequencer
// decodes the software reset command into warm, cold and power-off
// four-bit countdown for the system reset, memory clear window on cold
// power-off latch held until rst_p

`timescale 1ns/1ps
`default_nettype none

`include "pi1_sys_defines.svh"

module reset_seq (
	input  logic clk120mhz,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o,
	output logic ram_clear_o,
	output logic pwroff_o
);

	// long enough for the memory to walk every word once
	localparam int CLR_W = $clog2(`RAM_MAPSZ) + 2;

	logic [`RST_CNTR_W-1:0] rst_cntr_q;
	logic [CLR_W-1:0]       clr_cnt_q;
	logic                   ram_clear_q;
	logic                   pwroff_q;
	logic                   cmd_cold;
	logic                   cmd_warm;
	logic                   cmd_pwroff;

	assign cmd_cold   = rst0_i && rst1_i;
	assign cmd_warm   = !rst0_i && rst1_i;
	assign cmd_pwroff = rst0_i && !rst1_i;

	always_ff @(posedge clk120mhz) begin
		if (rst_p || cmd_warm || cmd_cold)
			rst_cntr_q <= '1;
		else if (|rst_cntr_q)
			rst_cntr_q <= rst_cntr_q - 1'b1;
	end

	// the clear starts one cycle after the pulse, hence the extra count
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			clr_cnt_q   <= '0;
			ram_clear_q <= 1'b0;
		end else begin
			ram_clear_q <= cmd_cold;
			if (cmd_cold)
				clr_cnt_q <= CLR_W'(`RAM_MAPSZ + 1);
			else if (|clr_cnt_q)
				clr_cnt_q <= clr_cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (cmd_pwroff)
			pwroff_q <= 1'b1;
	end

	// a command takes the bus down in the same cycle it shows up
	assign sys_rst_o   = (|rst_cntr_q) || (|clr_cnt_q) || pwroff_q || rst0_i || rst1_i;
	assign ram_clear_o = ram_clear_q;
	assign pwroff_o    = pwroff_q;

	a_cntr_reload_only: assert property (@(posedge clk120mhz)
		(rst_cntr_q > $past(rst_cntr_q)) |-> $past(rst_p || cmd_warm || cmd_cold));

	a_pwroff_sticky: assert property (@(posedge clk120mhz)
		$fell(pwroff_q) |-> $past(rst_p));

endmodule

`default_nettype wire

// ==== hw/word_ram.sv ====
// on-chip word memory on the PI1 bus
// byte-select writes, registered read, swap returns the old word
// cold clear walks every word while the system is held in reset

`timescale 1ns/1ps
`default_nettype none

`include "pi1_sys_defines.svh"

module word_ram (
	input  logic                   clk120mhz,
	input  logic                   sys_rst_i,
	input  logic                   ram_clear_i,
	input  pi1_sys_pkg::pi1_req_t  req_i,
	output logic [`PI1_DATA_W-1:0] data_o
);

	import pi1_sys_pkg::*;

	localparam int IDX_W = $clog2(`RAM_MAPSZ);

	logic [`PI1_DATA_W-1:0] mem [`RAM_MAPSZ];
	logic [`PI1_DATA_W-1:0] data_q;
	logic [IDX_W-1:0]       word_idx;
	logic [IDX_W-1:0]       clr_addr_q;
	logic                   clearing_q;
	logic                   wr_en;
	logic                   rd_en;

	assign word_idx = req_i.addr[IDX_W-1:0];
	assign wr_en    = (req_i.op == op_write) || (req_i.op == op_swap);
	assign rd_en    = (req_i.op == op_read) || (req_i.op == op_swap);

	// the walk only runs inside the reset window
	always_ff @(posedge clk120mhz) begin
		if (ram_clear_i) begin
			clearing_q <= 1'b1;
			clr_addr_q <= '0;
		end else if (clearing_q) begin
			if (!sys_rst_i || (&clr_addr_q))
				clearing_q <= 1'b0;
			clr_addr_q <= clr_addr_q + 1'b1;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (clearing_q && sys_rst_i) begin
			mem[clr_addr_q] <= '0;
		end else if (wr_en) begin
			for (int b = 0; b < `PI1_SEL_W; b++) begin
				if (req_i.sel[b])
					mem[word_idx][8*b +: 8] <= req_i.data[8*b +: 8];
			end
		end
		// old word, so a swap hands back what was there before
		if (rd_en)
			data_q <= mem[word_idx];
	end

	assign data_o = data_q;

endmodule

`default_nettype wire

// ==== pi1_sys_top.f ====
+incdir+hw
hw/pi1_sys_pkg.sv
hw/reset_seq.sv
hw/pi1_router.sv
hw/word_ram.sv
hw/dev_table.sv
hw/pi1_sys_top.sv
tests/tb_pi1_sys_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pi1_sys_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_pi1_sys_top
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f pi1_sys_top.f -o "V$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	echo "result: FAILED"
	exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
	echo "result: no pass line found in $LOG"
	exit 1
fi
echo "result: PASSED"
exit 0

// ==== tests/pi1_sys_patterns.txt ====
// test op addr data sel expected flag; op 1 write, 2 read, 3 swap
// flag 0 none, 1 compare read data, 2 reset command, 3 power-off then rst_p
1 1 00000010 11223344 f 00000000 0
1 1 00000010 aabbccdd 5 00000000 0
1 2 00000010 00000000 f 11bb33dd 1
1 1 00000011 00000000 f 00000000 0
1 1 00000011 cafef00d a 00000000 0
1 2 00000011 00000000 f ca00f000 1
1 1 000000ff deadbeef f 00000000 0
1 2 000000ff 00000000 f deadbeef 1
2 3 00000010 5555aaaa f 11bb33dd 1
2 2 00000010 00000000 f 5555aaaa 1
2 3 00000010 12345678 3 5555aaaa 1
2 2 00000010 00000000 f 55555678 1
3 2 00000100 00000000 f 01000100 1
3 2 00000101 00000000 f 07000010 1
3 2 00000102 00000000 f 00000000 1
3 2 00000103 00000000 f 00000000 1
4 2 00000110 00000000 f 00000000 1
4 1 00000110 ffffffff f 00000000 0
4 2 00000110 00000000 f 00000000 1
4 2 3fffffff 00000000 f 00000000 1
4 2 00000010 00000000 f 55555678 1
5 1 0000010f 00000002 1 00000000 2
5 2 00000010 00000000 f 55555678 1
5 2 000000ff 00000000 f deadbeef 1
5 1 0000010f 00000003 1 00000000 2
5 2 00000010 00000000 f 00000000 1
5 2 000000ff 00000000 f 00000000 1
5 2 00000011 00000000 f 00000000 1
6 1 0000010f 00000001 1 00000000 3
6 2 00000100 00000000 f 01000100 1

// ==== tests/tb_pi1_sys_top.sv ====
// testbench for the system-control fabric
// bus accesses and expected data come from the pattern file
// random byte-select merges are generated and checked here
// clock, reset, watchdog and one result line per test

`timescale 1ns/1ps
`default_nettype none

module tb_pi1_sys_top;

	import pi1_sys_pkg::*;

	// test, op, addr, data, sel, expected, flag
	localparam int COLS = 7;
	localparam int MAX_LINES = 64;

	logic     clk120mhz;
	logic     rst_p;
	pi1_req_t m_req_i;
	pi1_rsp_t m_rsp_o;
	logic     sys_rst_o;
	logic     pwroff_o;

	logic [31:0] pat [COLS*MAX_LINES];
	int          n_lines;
	logic        loaded;
	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;
	integer      seed;

	pi1_sys_top u_pi1_sys_top (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.m_req_i   (m_req_i),
		.m_rsp_o   (m_rsp_o),
		.sys_rst_o (sys_rst_o),
		.pwroff_o  (pwroff_o)
	);

	always #5 clk120mhz = ~clk120mhz;

	// inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk120mhz);
		#1;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		test_checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("FAIL at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
			$display("%s: ok, %0d checks", name, test_checks);
		else
			$display("%s: %0d of %0d checks wrong", name, test_errors, test_checks);
		test_checks = 0;
		test_errors = 0;
	endtask

	// one access, returns the data seen in the cycle after acceptance
	task automatic bus_access(input pi1_op_e op, input logic [29:0] addr,
		input logic [31:0] data, input logic [3:0] sel, output logic [31:0] rdata);
		while (sys_rst_o)
			step();
		check_value(32'(m_rsp_o.rdy), 32'd1, "rdy once sys_rst_o is low");
		m_req_i.op   = op;
		m_req_i.addr = addr;
		m_req_i.data = data;
		m_req_i.sel  = sel;
		step();
		rdata = m_rsp_o.data;
		m_req_i.op = op_none;
	endtask

	task automatic run_line(input int i);
		int          b;
		logic [31:0] rdata;
		b = i * COLS;
		bus_access(pi1_op_e'(pat[b+1][1:0]), pat[b+2][29:0], pat[b+3], pat[b+4][3:0], rdata);
		case (pat[b+6])
			32'd1: check_value(rdata, pat[b+5], $sformatf("read of %08h", pat[b+2]));
			32'd2: begin
				check_value(32'(sys_rst_o), 32'd1, "sys_rst_o after reset command");
				while (sys_rst_o)
					step();
			end
			32'd3: begin
				// well past the countdown, the latch must still hold the bus
				repeat (32)
					step();
				check_value(32'(pwroff_o), 32'd1, "pwroff_o after power-off");
				check_value(32'(m_rsp_o.rdy), 32'd0, "rdy while powered off");
				rst_p = 1'b1;
				repeat (2)
					step();
				rst_p = 1'b0;
				check_value(32'(pwroff_o), 32'd0, "pwroff_o after rst_p");
			end
			default: ;
		endcase
	endtask

	task automatic random_merges();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp;
		logic [31:0] rdata;
		logic [3:0]  s;
		logic [29:0] addr;
		for (int k = 0; k < 8; k++) begin
			addr = 30'h40 + 30'(k);
			a = $random(seed);
			b = $random(seed);
			s = 4'($random(seed));
			exp = a;
			for (int j = 0; j < 4; j++) begin
				if (s[j])
					exp[8*j +: 8] = b[8*j +: 8];
			end
			bus_access(op_write, addr, a, 4'hf, rdata);
			bus_access(op_write, addr, b, s, rdata);
			bus_access(op_read, addr, 32'h0, 4'hf, rdata);
			check_value(rdata, exp, $sformatf("random merge at %08h", addr));
		end
	endtask

	// limit grows with the number of pattern lines
	initial begin
		wait (loaded);
		repeat (n_lines * 40 + 2000)
			@(posedge clk120mhz);
		$display("timeout: the run did not finish within %0d cycles", n_lines * 40 + 2000);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] cur_test;
		clk120mhz = 1'b0;
		rst_p = 1'b1;
		m_req_i = '0;
		seed = 32'ha342_4ada;
		checks = 0;
		errors = 0;
		test_checks = 0;
		test_errors = 0;
		n_lines = 0;
		for (int i = 0; i < COLS*MAX_LINES; i++)
			pat[i] = '1;
		$readmemh("tests/pi1_sys_patterns.txt", pat);
		while (n_lines < MAX_LINES && pat[n_lines*COLS] != 32'hffff_ffff)
			n_lines++;
		loaded = 1'b1;
		if (n_lines == 0) begin
			$display("no pattern lines could be read from tests/pi1_sys_patterns.txt");
			errors++;
		end

		repeat (2)
			step();
		rst_p = 1'b0;
		check_value(32'(sys_rst_o), 32'd1, "sys_rst_o after rst_p");
		check_value(32'(m_rsp_o.rdy), 32'd0, "rdy after rst_p");
		check_value(32'(pwroff_o), 32'd0, "pwroff_o after rst_p");
		while (sys_rst_o)
			step();
		check_value(32'(m_rsp_o.rdy), 32'd1, "rdy after the countdown");
		finish_test("reset");

		cur_test = pat[0];
		for (int i = 0; i < n_lines; i++) begin
			if (pat[i*COLS] != cur_test) begin
				finish_test($sformatf("pattern test %0d", cur_test));
				cur_test = pat[i*COLS];
			end
			run_line(i);
		end
		if (n_lines > 0)
			finish_test($sformatf("pattern test %0d", cur_test));

		random_merges();
		finish_test("random merges");

		$display("checks run: %0d, wrong: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
